/* verilog.f */
+incdir+tests
rtl/csr_defs_pkg.sv
rtl/csr_bus_pkg.sv
rtl/counter_control.sv
rtl/event_counter.sv
rtl/trap_control.sv
rtl/csr_read_mux.sv
rtl/csr_unit.sv
tests/csr_unit_tb.sv

/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       = csr_unit_tb
FILE_LIST = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/csr_tb_cases.svh */
// Columns: operation, CSR address, data, expected value.
// For op_rand the expected column is the write mask, for op_count the address picks
// the pulse (0 exception, 1 mret), and data holds stage bits, irq lines or a strobe count.
typedef enum logic [3:0] {
  op_wr, op_rd, op_rand, op_exc, op_irq,
  op_mret, op_retire, op_count, op_vec, op_epc
} op_e;

typedef struct packed {
  op_e         op;
  logic [11:0] addr;
  logic [31:0] data;
  logic [31:0] exp;
} case_t;

localparam int num_cases = 45;

localparam case_t cases [num_cases] = '{
  '{op_wr,     csr_defs_pkg::csr_mscratch,      32'hcafe_f00d, 32'h0},
  '{op_rd,     csr_defs_pkg::csr_mscratch,      32'h0,         32'hcafe_f00d},
  '{op_wr,     csr_defs_pkg::csr_mepc,          32'h8000_1234, 32'h0},
  '{op_rd,     csr_defs_pkg::csr_mepc,          32'h0,         32'h8000_1234},
  '{op_rand,   csr_defs_pkg::csr_mstatus,       32'h0,         csr_defs_pkg::mstatus_wmask},
  '{op_rand,   csr_defs_pkg::csr_mie,           32'h0,         csr_defs_pkg::mie_wmask},
  '{op_wr,     csr_defs_pkg::csr_misa,          32'hffff_ffff, 32'h0},
  '{op_rd,     csr_defs_pkg::csr_misa,          32'h0,         csr_defs_pkg::misa_value},
  '{op_rd,     12'h7c0,                         32'h0,         32'h0},
  '{op_wr,     csr_defs_pkg::csr_mtvec,         32'h0000_0200, 32'h0},
  '{op_vec,    12'h0,                           32'h0,         32'h0000_0200},
  // Decode and memory raise together, decode must win.
  '{op_wr,     csr_defs_pkg::csr_mie,           32'h0,         32'h0},
  '{op_wr,     csr_defs_pkg::csr_mstatus,       32'h0000_0008, 32'h0},
  '{op_exc,    12'h0,                           32'h0000_0005, 32'h0},
  '{op_count,  12'h0,                           32'h0,         32'h1},
  '{op_rd,     csr_defs_pkg::csr_mepc,          32'h0,         32'h0000_1000},
  '{op_epc,    12'h0,                           32'h0,         32'h0000_1000},
  '{op_rd,     csr_defs_pkg::csr_mtval,         32'h0,         32'h0000_bad0},
  '{op_rd,     csr_defs_pkg::csr_mcause,        32'h0,         32'h0000_0002},
  '{op_rd,     csr_defs_pkg::csr_mstatus,       32'h0,         32'h0000_0080},
  // External interrupt, first disabled and then enabled.
  '{op_wr,     csr_defs_pkg::csr_mstatus,       32'h0000_0008, 32'h0},
  '{op_irq,    12'h0,                           32'h0000_0004, 32'h0},
  '{op_count,  12'h0,                           32'h0,         32'h0},
  '{op_wr,     csr_defs_pkg::csr_mie,           32'h0000_0800, 32'h0},
  '{op_count,  12'h0,                           32'h0,         32'h1},
  '{op_rd,     csr_defs_pkg::csr_mcause,        32'h0,         32'h8000_000b},
  '{op_irq,    12'h0,                           32'h0000_0003, 32'h0},
  '{op_wr,     csr_defs_pkg::csr_mie,           32'h0000_0888, 32'h0},
  '{op_wr,     csr_defs_pkg::csr_mstatus,       32'h0000_0008, 32'h0},
  '{op_count,  12'h0,                           32'h0,         32'h1},
  '{op_rd,     csr_defs_pkg::csr_mcause,        32'h0,         32'h8000_0007},
  '{op_wr,     csr_defs_pkg::csr_mtvec,         32'h0000_0201, 32'h0},
  '{op_vec,    12'h0,                           32'h0,         32'h0000_021c},
  '{op_irq,    12'h0,                           32'h0,         32'h0},
  '{op_mret,   12'h0,                           32'h0,         32'h0},
  '{op_count,  12'h1,                           32'h0,         32'h1},
  '{op_rd,     csr_defs_pkg::csr_mstatus,       32'h0,         32'h0000_0008},
  // Counters.
  '{op_wr,     csr_defs_pkg::csr_mcountinhibit, 32'h0000_0001, 32'h0},
  '{op_wr,     csr_defs_pkg::csr_mcycle,        32'h1234_5678, 32'h0},
  '{op_wr,     csr_defs_pkg::csr_mcycleh,       32'h9abc_def0, 32'h0},
  '{op_rd,     csr_defs_pkg::csr_mcycle,        32'h0,         32'h1234_5678},
  '{op_rd,     csr_defs_pkg::csr_mcycleh,       32'h0,         32'h9abc_def0},
  '{op_wr,     csr_defs_pkg::csr_minstret,      32'h0,         32'h0},
  '{op_retire, 12'h0,                           32'h0000_0005, 32'h0},
  '{op_rd,     csr_defs_pkg::csr_minstret,      32'h0,         32'h0000_0005}
};

/* tests/csr_unit_tb.sv */
`timescale 1ns/1ns

module csr_unit_tb;

  `include "csr_tb_cases.svh"

  logic                    clk;
  logic                    rst;
  csr_bus_pkg::csr_read_t  read;
  csr_bus_pkg::csr_write_t write;
  csr_bus_pkg::trap_src_t  trap_src [3];
  logic                    retire;
  logic                    mret_req;
  csr_bus_pkg::irq_lines_t irq;
  csr_bus_pkg::csr_resp_t  resp;

  integer      seed;
  int          failures;
  logic        check;
  logic        case_ok;
  logic [31:0] got;
  logic [31:0] want;

  csr_unit uut (
    .clk      (clk),
    .rst      (rst),
    .read     (read),
    .write    (write),
    .trap_src (trap_src),
    .retire   (retire),
    .mret_req (mret_req),
    .irq      (irq),
    .resp     (resp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // The longest entry takes well under 40 cycles.
  initial begin
    repeat (16 + num_cases * 40) @(posedge clk);
    $display("Timeout: the test sequence hung and did not reach its end");
    $display("=== FAIL ===");
    $finish;
  end

  task automatic drive_write(input logic [11:0] addr, input logic [31:0] data);
    @(posedge clk);
    write <= '{wen: 1'b1, waddr: addr, wdata: data};
    @(posedge clk);
    write <= '0;
  endtask

  task automatic read_back(input logic [11:0] addr, output logic [31:0] value);
    @(posedge clk);
    read <= '{rden: 1'b1, raddr: addr};
    @(negedge clk);
    value = resp.rdata;
  endtask

  // Stage s reports epc 0x1000 + 0x100*s, tval 0xbad0 + s and cause s + 2.
  task automatic raise_exceptions(input logic [2:0] stages);
    @(posedge clk);
    for (int s = 0; s < 3; s++) begin
      trap_src[s] <= '{valid: stages[s], exception: stages[s],
                       epc: 32'h1000 + 32'(s) * 32'h100,
                       etval: 32'hbad0 + 32'(s), ecause: 4'(s + 2)};
    end
    @(posedge clk);
    for (int s = 0; s < 3; s++) begin
      trap_src[s] <= '0;
    end
  endtask

  task automatic count_pulses(input logic mret_side, output logic [31:0] n);
    n = '0;
    repeat (4) begin
      @(negedge clk);
      if (mret_side ? resp.mret : resp.exception) begin
        n = n + 32'd1;
      end
    end
  endtask

  task automatic retire_burst(input logic [31:0] n);
    repeat (n) begin
      @(posedge clk);
      retire <= 1'b1;
    end
    @(posedge clk);
    retire <= 1'b0;
  endtask

  task automatic apply_case(input case_t c, output logic checked,
                            output logic [31:0] value, output logic [31:0] expected);
    logic [31:0] rnd;
    checked  = 1'b1;
    value    = '0;
    expected = c.exp;
    case (c.op)
      op_wr: begin
        drive_write(c.addr, c.data);
        checked = 1'b0;
      end
      op_rd: read_back(c.addr, value);
      op_rand: begin
        rnd = $random(seed);
        drive_write(c.addr, rnd);
        read_back(c.addr, value);
        expected = rnd & c.exp;
      end
      op_exc: begin
        raise_exceptions(c.data[2:0]);
        checked = 1'b0;
      end
      op_irq: begin
        @(posedge clk);
        irq <= csr_bus_pkg::irq_lines_t'(c.data[2:0]);
        checked = 1'b0;
      end
      op_mret: begin
        @(posedge clk);
        mret_req <= 1'b1;
        @(posedge clk);
        mret_req <= 1'b0;
        checked = 1'b0;
      end
      op_retire: begin
        retire_burst(c.data);
        checked = 1'b0;
      end
      op_count: count_pulses(c.addr[0], value);
      op_vec: begin
        @(negedge clk);
        value = resp.mtvec;
      end
      op_epc: begin
        @(negedge clk);
        value = resp.mepc;
      end
      default: checked = 1'b0;
    endcase
  endtask

  initial begin
    seed     = 32'h2b1d;
    failures = 0;
    rst      <= 1'b0;
    read     <= '0;
    write    <= '0;
    retire   <= 1'b0;
    mret_req <= 1'b0;
    irq      <= '0;
    for (int s = 0; s < 3; s++) begin
      trap_src[s] <= '0;
    end
    repeat (16) @(posedge clk);
    rst <= 1'b1;

    for (int i = 0; i < num_cases; i++) begin
      apply_case(cases[i], check, got, want);
      case_ok = 1'b1;
      if (check) begin
        assert (got == want) else begin
          $display("FAIL %0t: test %0d (%s) returned %h, expected %h",
                   $time, i, cases[i].op.name(), got, want);
          case_ok = 1'b0;
          failures++;
        end
      end
      if (case_ok) begin
        $display("test %0d (%s): ok", i, cases[i].op.name());
      end
    end

    $display("%0d tests, %0d passed, %0d failed", num_cases, num_cases - failures, failures);
    if (failures == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* rtl/csr_unit.sv */
`timescale 1ns/1ns

module csr_unit (
  input  logic                    clk,
  input  logic                    rst,
  input  csr_bus_pkg::csr_read_t  read,
  input  csr_bus_pkg::csr_write_t write,
  input  csr_bus_pkg::trap_src_t  trap_src [3],
  input  logic                    retire,
  input  logic                    mret_req,
  input  csr_bus_pkg::irq_lines_t irq,
  output csr_bus_pkg::csr_resp_t  resp
);

  csr_bus_pkg::counter_ctrl_t ctrl [csr_defs_pkg::num_counters];
  logic [63:0]                counter_value [csr_defs_pkg::num_counters];
  logic [31:0]                inhibit;
  csr_bus_pkg::trap_regs_t    regs;
  logic                       exception;
  logic                       mret;
  logic [31:0]                trap_vector;
  logic [31:0]                rdata;

  counter_control u_counter_control (
    .clk     (clk),
    .rst     (rst),
    .write   (write),
    .retire  (retire),
    .ctrl    (ctrl),
    .inhibit (inhibit)
  );

  // One counter per event. Index cnt_cycle is mcycle, cnt_instret is minstret.
  for (genvar i = 0; i < csr_defs_pkg::num_counters; i++) begin : g_counter
    event_counter u_event_counter (
      .clk   (clk),
      .rst   (rst),
      .ctrl  (ctrl[i]),
      .value (counter_value[i])
    );
  end

  trap_control u_trap_control (
    .clk         (clk),
    .rst         (rst),
    .write       (write),
    .trap_src    (trap_src),
    .mret_req    (mret_req),
    .irq         (irq),
    .regs        (regs),
    .exception   (exception),
    .mret        (mret),
    .trap_vector (trap_vector)
  );

  csr_read_mux u_csr_read_mux (
    .read     (read),
    .regs     (regs),
    .counters (counter_value),
    .inhibit  (inhibit),
    .rdata    (rdata)
  );

  assign resp = '{rdata: rdata, exception: exception, mret: mret,
                  mepc: regs.mepc, mtvec: trap_vector};

endmodule

/* rtl/csr_read_mux.sv */
`timescale 1ns/1ns

module csr_read_mux (
  input  csr_bus_pkg::csr_read_t  read,
  input  csr_bus_pkg::trap_regs_t regs,
  input  logic [63:0]             counters [csr_defs_pkg::num_counters],
  input  logic [31:0]             inhibit,
  output logic [31:0]             rdata
);

  logic [31:0] mstatus_word;
  logic [31:0] mie_word;
  logic [31:0] mip_word;
  logic [63:0] cycle_value;
  logic [63:0] instret_value;

  // mpie at bit 7, mie at bit 3.
  assign mstatus_word = {24'd0, regs.mstatus.mpie, 3'd0, regs.mstatus.mie, 3'd0};

  assign mie_word = {20'd0, regs.mie.meie, 3'd0, regs.mie.mtie, 3'd0, regs.mie.msie, 3'd0};
  assign mip_word = {20'd0, regs.mip.meip, 3'd0, regs.mip.mtip, 3'd0, regs.mip.msip, 3'd0};

  assign cycle_value   = counters[csr_defs_pkg::cnt_cycle];
  assign instret_value = counters[csr_defs_pkg::cnt_instret];

  always_comb begin
    rdata = '0;
    if (read.rden) begin
      case (read.raddr)
        csr_defs_pkg::csr_mstatus:       rdata = mstatus_word;
        csr_defs_pkg::csr_misa:          rdata = csr_defs_pkg::misa_value;
        csr_defs_pkg::csr_mie:           rdata = mie_word;
        csr_defs_pkg::csr_mtvec:         rdata = regs.mtvec;
        csr_defs_pkg::csr_mcountinhibit: rdata = inhibit;
        csr_defs_pkg::csr_mscratch:      rdata = regs.mscratch;
        csr_defs_pkg::csr_mepc:          rdata = regs.mepc;
        csr_defs_pkg::csr_mcause:        rdata = regs.mcause;
        csr_defs_pkg::csr_mtval:         rdata = regs.mtval;
        csr_defs_pkg::csr_mip:           rdata = mip_word;
        csr_defs_pkg::csr_mcycle:        rdata = cycle_value[31:0];
        csr_defs_pkg::csr_mcycleh:       rdata = cycle_value[63:32];
        csr_defs_pkg::csr_minstret:      rdata = instret_value[31:0];
        csr_defs_pkg::csr_minstreth:     rdata = instret_value[63:32];
        default:                         rdata = '0;
      endcase
    end
  end

endmodule

/* rtl/trap_control.sv */
`timescale 1ns/1ns

module trap_control (
  input  logic                    clk,
  input  logic                    rst,
  input  csr_bus_pkg::csr_write_t write,
  input  csr_bus_pkg::trap_src_t  trap_src [3],
  input  logic                    mret_req,
  input  csr_bus_pkg::irq_lines_t irq,
  output csr_bus_pkg::trap_regs_t regs,
  output logic                    exception,
  output logic                    mret,
  output logic [31:0]             trap_vector
);

  logic        exc_found;
  logic [1:0]  exc_sel;
  logic        epc_found;
  logic [31:0] irq_epc;
  logic        irq_take;
  logic [3:0]  irq_cause;
  logic        trap_take;
  logic [31:0] trap_epc;
  logic [31:0] trap_tval;
  logic [31:0] trap_cause;
  logic [31:0] mstatus_wr;
  logic [31:0] mie_wr;
  logic [31:0] vec_base;

  assign mstatus_wr = write.wdata & csr_defs_pkg::mstatus_wmask;
  assign mie_wr     = write.wdata & csr_defs_pkg::mie_wmask;

  // Decode has the highest priority, memory the lowest.
  always_comb begin
    exc_found = 1'b0;
    exc_sel   = 2'd0;
    epc_found = 1'b0;
    irq_epc   = regs.mepc;
    for (int i = 0; i < 3; i++) begin
      if (!exc_found && trap_src[i].exception) begin
        exc_found = 1'b1;
        exc_sel   = 2'(i);
      end
      if (!epc_found && trap_src[i].valid) begin
        epc_found = 1'b1;
        irq_epc   = trap_src[i].epc;
      end
    end
  end

  always_comb begin
    irq_take  = 1'b0;
    irq_cause = csr_defs_pkg::cause_mach_extern;
    if (regs.mstatus.mie) begin
      if (regs.mip.meip && regs.mie.meie) begin
        irq_take  = 1'b1;
        irq_cause = csr_defs_pkg::cause_mach_extern;
      end else if (regs.mip.mtip && regs.mie.mtie) begin
        irq_take  = 1'b1;
        irq_cause = csr_defs_pkg::cause_mach_timer;
      end else if (regs.mip.msip && regs.mie.msie) begin
        irq_take  = 1'b1;
        irq_cause = csr_defs_pkg::cause_mach_soft;
      end
    end
  end

  always_comb begin
    trap_take = exc_found || irq_take;
    if (exc_found) begin
      trap_epc   = trap_src[exc_sel].epc;
      trap_tval  = trap_src[exc_sel].etval;
      trap_cause = {28'd0, trap_src[exc_sel].ecause};
    end else begin
      // Interrupts carry no trap value.
      trap_epc   = irq_epc;
      trap_tval  = '0;
      trap_cause = {1'b1, 27'd0, irq_cause};
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      regs      <= '0;
      exception <= 1'b0;
      mret      <= 1'b0;
    end else begin
      regs.mip.meip <= irq.meip;
      regs.mip.mtip <= irq.mtip;
      regs.mip.msip <= irq.msip;

      if (write.wen) begin
        case (write.waddr)
          csr_defs_pkg::csr_mstatus: begin
            regs.mstatus.mpie <= mstatus_wr[7];
            regs.mstatus.mie  <= mstatus_wr[3];
          end
          csr_defs_pkg::csr_mie: begin
            regs.mie.meie <= mie_wr[11];
            regs.mie.mtie <= mie_wr[7];
            regs.mie.msie <= mie_wr[3];
          end
          csr_defs_pkg::csr_mtvec:    regs.mtvec    <= write.wdata;
          csr_defs_pkg::csr_mscratch: regs.mscratch <= write.wdata;
          csr_defs_pkg::csr_mepc:     regs.mepc     <= write.wdata;
          csr_defs_pkg::csr_mcause:   regs.mcause   <= write.wdata;
          csr_defs_pkg::csr_mtval:    regs.mtval    <= write.wdata;
          default: ;
        endcase
      end

      // Trap entry and mret come last so they override a write in the same cycle.
      if (trap_take) begin
        regs.mstatus.mpie <= regs.mstatus.mie;
        regs.mstatus.mie  <= 1'b0;
        regs.mepc         <= trap_epc;
        regs.mtval        <= trap_tval;
        regs.mcause       <= trap_cause;
      end else if (mret_req) begin
        regs.mstatus.mie  <= regs.mstatus.mpie;
        regs.mstatus.mpie <= 1'b0;
      end

      exception <= trap_take;
      mret      <= mret_req && !trap_take;
    end
  end

  assign vec_base = {regs.mtvec[31:2], 2'b00};

  // Vectored mode adds four bytes per cause code.
  always_comb begin
    if (regs.mtvec[1:0] == 2'b01) begin
      trap_vector = vec_base + {26'd0, regs.mcause[3:0], 2'b00};
    end else begin
      trap_vector = vec_base;
    end
  end

endmodule

/* rtl/event_counter.sv */
`timescale 1ns/1ns

module event_counter (
  input  logic                       clk,
  input  logic                       rst,
  input  csr_bus_pkg::counter_ctrl_t ctrl,
  output logic [63:0]                value
);

  // A write to either half suppresses the increment for that cycle.
  always_ff @(posedge clk) begin
    if (!rst) begin
      value <= '0;
    end else if (ctrl.load_lo || ctrl.load_hi) begin
      if (ctrl.load_lo) begin
        value[31:0] <= ctrl.data;
      end
      if (ctrl.load_hi) begin
        value[63:32] <= ctrl.data;
      end
    end else if (ctrl.inc) begin
      value <= value + 64'd1;
    end
  end

endmodule

/* rtl/counter_control.sv */
`timescale 1ns/1ns

module counter_control (
  input  logic                      clk,
  input  logic                      rst,
  input  csr_bus_pkg::csr_write_t   write,
  input  logic                      retire,
  output csr_bus_pkg::counter_ctrl_t ctrl [csr_defs_pkg::num_counters],
  output logic [31:0]               inhibit
);

  logic wr_inhibit;

  assign wr_inhibit = write.wen && (write.waddr == csr_defs_pkg::csr_mcountinhibit);

  always_ff @(posedge clk) begin
    if (!rst) begin
      inhibit <= '0;
    end else if (wr_inhibit) begin
      inhibit <= write.wdata & csr_defs_pkg::mcountinhibit_wmask;
    end
  end

  always_comb begin
    for (int i = 0; i < csr_defs_pkg::num_counters; i++) begin
      ctrl[i].data = write.wdata;
    end

    ctrl[csr_defs_pkg::cnt_cycle].load_lo =
      write.wen && (write.waddr == csr_defs_pkg::csr_mcycle);
    ctrl[csr_defs_pkg::cnt_cycle].load_hi =
      write.wen && (write.waddr == csr_defs_pkg::csr_mcycleh);
    ctrl[csr_defs_pkg::cnt_instret].load_lo =
      write.wen && (write.waddr == csr_defs_pkg::csr_minstret);
    ctrl[csr_defs_pkg::cnt_instret].load_hi =
      write.wen && (write.waddr == csr_defs_pkg::csr_minstreth);

    // The inhibit bit of each counter sits at the low bits of its address.
    ctrl[csr_defs_pkg::cnt_cycle].inc   = ~inhibit[0];
    ctrl[csr_defs_pkg::cnt_instret].inc = retire & ~inhibit[2];
  end

endmodule

/* rtl/csr_bus_pkg.sv */
package csr_bus_pkg;

  typedef struct packed {
    logic        rden;
    logic [11:0] raddr;
  } csr_read_t;

  typedef struct packed {
    logic        wen;
    logic [11:0] waddr;
    logic [31:0] wdata;
  } csr_write_t;

  // One per pipeline stage. The exception flag is a level held by the stage.
  typedef struct packed {
    logic        valid;
    logic        exception;
    logic [31:0] epc;
    logic [31:0] etval;
    logic [3:0]  ecause;
  } trap_src_t;

  typedef struct packed {
    logic meip;
    logic mtip;
    logic msip;
  } irq_lines_t;

  typedef struct packed {
    logic        load_lo;
    logic        load_hi;
    logic        inc;
    logic [31:0] data;
  } counter_ctrl_t;

  typedef struct packed {
    logic mpie;
    logic mie;
  } mstatus_t;

  typedef struct packed {
    logic meie;
    logic mtie;
    logic msie;
  } mie_t;

  typedef struct packed {
    logic meip;
    logic mtip;
    logic msip;
  } mip_t;

  typedef struct packed {
    mstatus_t    mstatus;
    mie_t        mie;
    mip_t        mip;
    logic [31:0] mtvec;
    logic [31:0] mscratch;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mtval;
  } trap_regs_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        exception;
    logic        mret;
    logic [31:0] mepc;
    logic [31:0] mtvec;
  } csr_resp_t;

endpackage

/* rtl/csr_defs_pkg.sv */
package csr_defs_pkg;

  // Machine-mode CSR addresses served by the unit.
  typedef enum logic [11:0] {
    csr_mstatus       = 12'h300,
    csr_misa          = 12'h301,
    csr_mie           = 12'h304,
    csr_mtvec         = 12'h305,
    csr_mcountinhibit = 12'h320,
    csr_mscratch      = 12'h340,
    csr_mepc          = 12'h341,
    csr_mcause        = 12'h342,
    csr_mtval         = 12'h343,
    csr_mip           = 12'h344,
    csr_mcycle        = 12'hB00,
    csr_minstret      = 12'hB02,
    csr_mcycleh       = 12'hB80,
    csr_minstreth     = 12'hB82
  } csr_addr_e;

  // Interrupt cause codes, placed in mcause[3:0] with mcause[31] set.
  localparam logic [3:0] cause_mach_extern = 4'd11;
  localparam logic [3:0] cause_mach_timer  = 4'd7;
  localparam logic [3:0] cause_mach_soft   = 4'd3;

  localparam int num_counters = 2;
  localparam int cnt_cycle    = 0;
  localparam int cnt_instret  = 1;

  // Only mie (bit 3) and mpie (bit 7) exist in mstatus.
  localparam logic [31:0] mstatus_wmask = 32'h0000_0088;

  // meie, mtie and msie.
  localparam logic [31:0] mie_wmask = 32'h0000_0888;

  // The machine pending bits follow the interrupt lines and cannot be set by software.
  localparam logic [31:0] mip_wmask = 32'h0000_0000;

  // cy (bit 0) and ir (bit 2).
  localparam logic [31:0] mcountinhibit_wmask = 32'h0000_0005;

  // MXL = 1 for RV32, with the I and M extensions.
  localparam logic [31:0] misa_value = 32'h4000_1100;

endpackage
